//--- tb.f
color_proc_pkg.sv
filter_select.sv
frame_scanner.sv
bin_counter.sv
hist_snapshot.sv
color_proc_top.sv
tb_color_proc.sv

//--- run.sh
#!/bin/sh
# builds the color filter testbench with verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_color_proc -f tb.f
out=$(./obj_dir/Vtb_color_proc)
echo "$out"
echo "$out" | grep -qx "Result: PASSED"

//--- tb_color_proc.sv
/*
  tb_color_proc
  testbench for the color filter and spatial histogram engine
  models both image memories, steps the filter mask, runs a table of
  frames and checks the processed image, bins, total and frame pulse
*/
`default_nettype none

module tb_color_proc
  import color_proc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // table row with pattern 0 for solid, 1 for stripes and 2 for random
  typedef struct packed {
    logic [3:0] pulses;
    logic [1:0] pat;
    rgb_mask_t  color;
    logic       dbl;
  } test_row_t;

  logic         clk;
  logic         rst;
  logic         proc_ctrl_i;
  logic         new_frame_i;
  pxl_t         orig_pxl_i;
  addr_t        orig_addr_o;
  logic         proc_we_o;
  addr_t        proc_addr_o;
  pxl_t         proc_pxl_o;
  bin_cnt_vec_t histogram_o;
  total_cnt_t   colorpxls_o;
  logic         new_frame_proc_o;
  rgb_mask_t    rgbfilter_o;

  pxl_t         orig_mem [img_pxls];
  pxl_t         proc_mem [img_pxls];
  pxl_t         exp_mem [img_pxls];
  int           write_cnt [img_pxls];
  int           exp_bins [hist_bins];
  int           exp_total;
  rgb_mask_t    mask_seq [8];
  test_row_t    tests [8];
  int           mask_pos;
  logic [15:0]  lfsr;
  addr_t        rd_addr;
  int           err_cnt;
  int           chk_cnt;
  int           pulse_cnt = 0;
  int           errs;
  bit           timed_out;

  color_proc_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .proc_ctrl_i      (proc_ctrl_i),
    .new_frame_i      (new_frame_i),
    .orig_pxl_i       (orig_pxl_i),
    .orig_addr_o      (orig_addr_o),
    .proc_we_o        (proc_we_o),
    .proc_addr_o      (proc_addr_o),
    .proc_pxl_o       (proc_pxl_o),
    .histogram_o      (histogram_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o),
    .rgbfilter_o      (rgbfilter_o)
  );

  always #20 clk = ~clk;

  // source memory returns the word one cycle after its address
  always begin
    @(negedge clk);
    rd_addr = orig_addr_o;
    @(posedge clk);
    #2;
    orig_pxl_i = orig_mem[rd_addr];
  end

  // processed memory and frame pulse counter sampled mid cycle
  always @(negedge clk) begin
    if (proc_we_o) begin
      proc_mem[proc_addr_o] = proc_pxl_o;
      write_cnt[proc_addr_o]++;
    end
    if (new_frame_proc_o) pulse_cnt++;
  end

  task automatic report_error(input string msg);
    err_cnt++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_mask(input rgb_mask_t got, input rgb_mask_t want, input string what);
    chk_cnt++;
    if (got !== want) report_error($sformatf("%s: mask %b, expected %b", what, got, want));
  endtask

  task automatic check_pxl(input pxl_t got, input pxl_t want, input int addr);
    chk_cnt++;
    if (got !== want) report_error($sformatf("pixel %0d: %h, expected %h", addr, got, want));
  endtask

  task automatic check_bin(input bin_cnt_t got, input bin_cnt_t want, input int bin);
    chk_cnt++;
    if (got !== want) report_error($sformatf("bin %0d: %0d, expected %0d", bin, got, want));
  endtask

  task automatic check_total(input total_cnt_t got, input total_cnt_t want);
    chk_cnt++;
    if (got !== want) report_error($sformatf("colorpxls_o: %0d, expected %0d", got, want));
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    chk_cnt++;
    if (got !== want) report_error($sformatf("%s: %b, expected %b", what, got, want));
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one proc_ctrl_i pulse held until the mask moves
  task automatic step_filter();
    int k;
    mask_pos = (mask_pos + 1) % 8;
    proc_ctrl_i = 1'b1;
    k = 0;
    while (rgbfilter_o !== mask_seq[mask_pos] && k < 8) begin
      @(posedge clk);
      #2;
      k++;
    end
    proc_ctrl_i = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    check_mask(rgbfilter_o, mask_seq[mask_pos], "rgbfilter_o after proc_ctrl_i pulse");
  endtask

  // fills the source memory and builds the expected image and bins
  task automatic prepare_frame(input int t);
    int col;
    int row;
    logic [11:0] bits;
    logic [8:0] low;
    rgb_mask_t msb;
    rgb_mask_t m;
    pxl_t p;
    bit pass;
    m = mask_seq[mask_pos];
    exp_total = 0;
    for (int b = 0; b < hist_bins; b++) exp_bins[b] = 0;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      // low bits fold in the whole address
      low = 9'(a ^ (a >> 6) ^ (a >> 12));
      msb = tests[t].color;
      if (tests[t].pat == 2'd1) msb = rgb_mask_t'(3'((col / bin_cols) % 8));
      bits = {msb.red, low[8:6], msb.green, low[5:3], msb.blue, low[2:0]};
      if (tests[t].pat == 2'd2) begin
        for (int i = 0; i < 12; i++) begin
          bits = {bits[10:0], lfsr[0]};
          lfsr = lfsr_next(lfsr);
        end
      end
      p = pxl_t'(bits);
      orig_mem[a] = p;
      pass = (m == 3'b000) || ({p.red[3], p.green[3], p.blue[3]} == m);
      exp_mem[a] = pass ? p : '0;
      write_cnt[a] = 0;
      if (pass && col >= outframe_cols && col < img_cols - outframe_cols &&
          row >= outframe_rows && row < img_rows - outframe_rows) begin
        exp_bins[(col - outframe_cols) / bin_cols]++;
        exp_total++;
      end
    end
  endtask

  task automatic check_results();
    for (int b = 0; b < hist_bins; b++) check_bin(histogram_o[b], bin_cnt_t'(exp_bins[b]), b);
    check_total(colorpxls_o, total_cnt_t'(exp_total));
  endtask

  // pulses new_frame_i and waits for new_frame_proc_o
  task automatic run_frame(input int t);
    int k;
    bit seen;
    new_frame_i = 1'b1;
    k = 0;
    seen = 1'b0;
    while (!seen && k < 2 * img_pxls) begin
      @(posedge clk);
      #2;
      k++;
      // optional second start request in the middle of the scan
      new_frame_i = tests[t].dbl && (k == 5000);
      seen = new_frame_proc_o;
    end
    if (!seen) begin
      $display("test %0d: timeout, new_frame_proc_o never pulsed", t);
      timed_out = 1'b1;
    end else begin
      chk_cnt++;
      if (k != img_pxls + 3) report_error($sformatf("frame took %0d cycles, expected %0d",
                                                    k, img_pxls + 3));
      check_results();
      @(posedge clk);
      #2;
      check_flag(new_frame_proc_o, 1'b0, "new_frame_proc_o one cycle after pulse");
      chk_cnt++;
      if (pulse_cnt != t + 1) report_error($sformatf("%0d frame pulses, expected %0d",
                                                     pulse_cnt, t + 1));
    end
  endtask

  task automatic check_image();
    for (int a = 0; a < img_pxls; a++) begin
      chk_cnt++;
      if (write_cnt[a] != 1) report_error($sformatf("address %0d written %0d times",
                                                    a, write_cnt[a]));
      check_pxl(proc_mem[a], exp_mem[a], a);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    proc_ctrl_i = 1'b0;
    new_frame_i = 1'b0;
    orig_pxl_i = '0;
    err_cnt = 0;
    chk_cnt = 0;
    timed_out = 1'b0;
    lfsr = 16'd34;
    mask_pos = 0;
    mask_seq = '{3'b000, 3'b100, 3'b010, 3'b001, 3'b110, 3'b101, 3'b011, 3'b111};
    // pulses before the frame, pattern, solid color, mid scan restart
    tests[0] = '{4'd0, 2'd0, 3'b100, 1'b0};
    tests[1] = '{4'd1, 2'd0, 3'b100, 1'b0};
    tests[2] = '{4'd1, 2'd0, 3'b100, 1'b0};
    tests[3] = '{4'd1, 2'd1, 3'b000, 1'b0};
    tests[4] = '{4'd2, 2'd1, 3'b000, 1'b0};
    tests[5] = '{4'd3, 2'd2, 3'b000, 1'b0};
    tests[6] = '{4'd1, 2'd2, 3'b000, 1'b1};
    tests[7] = '{4'd3, 2'd2, 3'b000, 1'b0};
    for (int b = 0; b < hist_bins; b++) exp_bins[b] = 0;
    exp_total = 0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    errs = err_cnt;
    check_mask(rgbfilter_o, 3'b000, "rgbfilter_o after reset");
    check_flag(new_frame_proc_o, 1'b0, "new_frame_proc_o after reset");
    check_flag(proc_we_o, 1'b0, "proc_we_o after reset");
    check_flag(orig_addr_o == '0, 1'b1, "orig_addr_o zero after reset");
    check_results();
    $display("test reset: %s", (err_cnt == errs) ? "ok" : "errors");
    errs = err_cnt;
    // full mask cycle that ends back at no filtering
    for (int i = 0; i < 8; i++) step_filter();
    $display("test mask cycle: %s", (err_cnt == errs) ? "ok" : "errors");
    for (int t = 0; t < 8 && !timed_out; t++) begin
      errs = err_cnt;
      for (int i = 0; i < int'(tests[t].pulses); i++) step_filter();
      // previous results still held
      check_results();
      prepare_frame(t);
      run_frame(t);
      if (!timed_out) check_image();
      $display("test %0d pattern %0d mask %b: %s", t, tests[t].pat, mask_seq[mask_pos],
               (err_cnt == errs && !timed_out) ? "ok" : "errors");
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- color_proc_top.sv
/*
  color_proc_top
  color filter and spatial histogram engine for a 160x120 frame
  filter_select picks the mask, frame_scanner filters the image and feeds
  eight bin counters, hist_snapshot publishes the histogram at frame end
*/
`default_nettype none

module color_proc_top
  import color_proc_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  proc_ctrl_i,
  input  wire logic  new_frame_i,
  // source image memory, one cycle read latency
  input  wire pxl_t  orig_pxl_i,
  output addr_t      orig_addr_o,
  // processed image memory
  output logic       proc_we_o,
  output addr_t      proc_addr_o,
  output pxl_t       proc_pxl_o,
  // histogram results
  output bin_cnt_vec_t histogram_o,
  output total_cnt_t colorpxls_o,
  output logic       new_frame_proc_o,
  output rgb_mask_t  rgbfilter_o
);

  hist_beat_t   beat;
  logic         frame_done;
  bin_cnt_vec_t bin_cnts;

  filter_select u_filter_select (
    .clk         (clk),
    .rst         (rst),
    .proc_ctrl_i (proc_ctrl_i),
    .filter_o    (rgbfilter_o)
  );

  frame_scanner u_frame_scanner (
    .clk          (clk),
    .rst          (rst),
    .new_frame_i  (new_frame_i),
    .filter_i     (rgbfilter_o),
    .orig_pxl_i   (orig_pxl_i),
    .orig_addr_o  (orig_addr_o),
    .proc_we_o    (proc_we_o),
    .proc_addr_o  (proc_addr_o),
    .proc_pxl_o   (proc_pxl_o),
    .beat_o       (beat),
    .frame_done_o (frame_done)
  );

  // one counter per column bin, 0 is the leftmost
  for (genvar g = 0; g < hist_bins; g++) begin : g_bin
    bin_counter #(
      .bin_idx (g)
    ) u_bin_counter (
      .clk     (clk),
      .rst     (rst),
      .beat_i  (beat),
      .count_o (bin_cnts[g])
    );
  end

  hist_snapshot u_hist_snapshot (
    .clk              (clk),
    .rst              (rst),
    .frame_done_i     (frame_done),
    .bins_i           (bin_cnts),
    .histogram_o      (histogram_o),
    .colorpxls_o      (colorpxls_o),
    .new_frame_proc_o (new_frame_proc_o)
  );

endmodule

`default_nettype wire

//--- hist_snapshot.sv
/*
  hist_snapshot
  captures the eight bin counts and their total when the frame ends and
  pulses new_frame_proc_o, outputs hold until the next frame
*/
`default_nettype none

module hist_snapshot
  import color_proc_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         frame_done_i,
  input  wire bin_cnt_vec_t bins_i,
  output bin_cnt_vec_t      histogram_o,
  output total_cnt_t        colorpxls_o,
  output logic              new_frame_proc_o
);

  total_cnt_t bin_sum;

  // total of the bins, only sampled at frame end
  always_comb begin
    bin_sum = '0;
    for (int i = 0; i < hist_bins; i++) begin
      bin_sum = bin_sum + total_cnt_t'(bins_i[i]);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      histogram_o      <= '0;
      colorpxls_o      <= '0;
      new_frame_proc_o <= 1'b0;
    end else begin
      new_frame_proc_o <= frame_done_i;
      if (frame_done_i) begin
        histogram_o <= bins_i;
        colorpxls_o <= bin_sum;
      end
    end
  end

endmodule

`default_nettype wire

//--- bin_counter.sv
/*
  bin_counter
  one histogram bin that counts the passing inner frame pixels whose
  column falls in bin number bin_idx and restarts on the first beat of a frame
*/
`default_nettype none

module bin_counter
  import color_proc_pkg::*;
#(
  parameter int unsigned bin_idx = 0
)
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire hist_beat_t beat_i,
  output bin_cnt_t        count_o
);

  logic inc;

  assign inc = beat_i.hit && (beat_i.bin == bin_idx_t'(bin_idx));

  // count holds between frames
  // pixel 0 lies outside the inner frame so a new frame starts from zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count_o <= '0;
    end else if (beat_i.valid) begin
      if (beat_i.first) begin
        count_o <= '0;
      end else if (inc) begin
        count_o <= count_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- frame_scanner.sv
/*
  frame_scanner
  walks the source image once per new_frame_i, filters each returning
  pixel, writes it to the processed memory and sends one histogram beat
  per pixel to the bin counters, then flags the end of the frame
*/
`default_nettype none

module frame_scanner
  import color_proc_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      new_frame_i,
  input  wire rgb_mask_t filter_i,
  input  wire pxl_t      orig_pxl_i,
  output addr_t          orig_addr_o,
  output logic           proc_we_o,
  output addr_t          proc_addr_o,
  output pxl_t           proc_pxl_o,
  output hist_beat_t     beat_o,
  output logic           frame_done_o
);

  logic     processing;
  logic     end_pxl;
  logic     end_ln;
  col_t     col;
  row_t     row;
  // column and row aligned with the returning pixel
  col_t     col_d;
  row_t     row_d;
  col_t     col_in;
  logic     inner;
  logic     match;
  rgb_mask_t pxl_msb;

  assign end_pxl = (orig_addr_o == addr_t'(img_pxls - 1));
  assign end_ln  = (col == col_t'(img_cols - 1));

  // source address, new_frame_i is ignored while scanning
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      processing  <= 1'b0;
      orig_addr_o <= '0;
    end else if (processing) begin
      if (end_pxl) begin
        processing  <= 1'b0;
        orig_addr_o <= '0;
      end else begin
        orig_addr_o <= orig_addr_o + 1'b1;
      end
    end else if (new_frame_i) begin
      processing <= 1'b1;
    end
  end

  // column and row follow the address
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else if (processing && !end_pxl) begin
      if (end_ln) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end else begin
      col <= '0;
      row <= '0;
    end
  end

  // memory read latency is one cycle, so delay the write side by one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      proc_we_o   <= 1'b0;
      proc_addr_o <= '0;
      col_d       <= '0;
      row_d       <= '0;
    end else begin
      proc_we_o   <= processing;
      proc_addr_o <= orig_addr_o;
      col_d       <= col;
      row_d       <= row;
    end
  end

  // red, green, blue msbs in mask bit order
  assign pxl_msb = {orig_pxl_i.red[3], orig_pxl_i.green[3], orig_pxl_i.blue[3]};

  // no mask passes all, otherwise msbs must equal the mask exactly
  assign match      = (filter_i == 3'b000) || (pxl_msb == filter_i);
  assign proc_pxl_o = match ? orig_pxl_i : '0;

  // inner frame is columns 16..143, rows 8..111
  assign inner = (col_d >= col_t'(outframe_cols)) &&
                 (col_d <  col_t'(img_cols - outframe_cols)) &&
                 (row_d >= row_t'(outframe_rows)) &&
                 (row_d <  row_t'(img_rows - outframe_rows));

  assign col_in = col_d - col_t'(outframe_cols);

  always_comb begin
    beat_o.valid = proc_we_o;
    beat_o.first = proc_we_o && (proc_addr_o == '0);
    beat_o.last  = proc_we_o && (proc_addr_o == addr_t'(img_pxls - 1));
    beat_o.hit   = proc_we_o && inner && match;
    // out of range values are masked by hit
    beat_o.bin   = bin_idx_t'(col_in / col_t'(bin_cols));
  end

  // one cycle after the last beat
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= beat_o.valid && beat_o.last;
    end
  end

endmodule

`default_nettype wire

//--- filter_select.sv
/*
  filter_select
  synchronizes the proc_ctrl_i button, detects its rising edge and steps
  the color mask through its fixed eight entry cycle
*/
`default_nettype none

module filter_select
  import color_proc_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      proc_ctrl_i,
  output rgb_mask_t      filter_o
);

  logic [1:0] ctrl_sync;
  logic       ctrl_prev;
  logic       ctrl_rise;
  rgb_mask_t  filter_nxt;

  // two flop synchronizer plus one more stage for the edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_sync <= '0;
      ctrl_prev <= 1'b0;
    end else begin
      ctrl_sync <= {ctrl_sync[0], proc_ctrl_i};
      ctrl_prev <= ctrl_sync[1];
    end
  end

  assign ctrl_rise = ctrl_sync[1] & ~ctrl_prev;

  // mask order: none, r, g, b, rg, rb, gb, rgb
  always_comb begin
    case (filter_o)
      3'b000:  filter_nxt = 3'b100;
      3'b100:  filter_nxt = 3'b010;
      3'b010:  filter_nxt = 3'b001;
      3'b001:  filter_nxt = 3'b110;
      3'b110:  filter_nxt = 3'b101;
      3'b101:  filter_nxt = 3'b011;
      3'b011:  filter_nxt = 3'b111;
      default: filter_nxt = 3'b000;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      filter_o <= '0;
    end else if (ctrl_rise) begin
      filter_o <= filter_nxt;
    end
  end

endmodule

`default_nettype wire

//--- color_proc_pkg.sv
/*
  color_proc_pkg
  shared image geometry, histogram sizes and the packed types that carry
  pixels, filter masks, scan beats and bin counts between the blocks of
  the color filter and spatial histogram engine
*/
`default_nettype none

package color_proc_pkg;

  // qqvga frame
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;

  // margins dropped on each side for the histogram
  localparam int outframe_cols = 16;
  localparam int outframe_rows = 8;
  localparam int inframe_cols  = img_cols - 2 * outframe_cols;
  localparam int inframe_rows  = img_rows - 2 * outframe_rows;

  // column bins of the inner frame
  localparam int hist_bins = 8;
  localparam int bin_cols  = inframe_cols / hist_bins;

  typedef logic [$clog2(img_pxls)-1:0]                 addr_t;
  typedef logic [$clog2(img_cols)-1:0]                 col_t;
  typedef logic [$clog2(img_rows)-1:0]                 row_t;
  typedef logic [$clog2(hist_bins)-1:0]                bin_idx_t;
  // 104 rows x 16 columns, so 1664 at most
  typedef logic [$clog2(inframe_rows * bin_cols)-1:0]  bin_cnt_t;
  typedef logic [$clog2(inframe_rows * inframe_cols)-1:0] total_cnt_t;

  // memory word, 4 bits per color
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pxl_t;

  // filter selection, all zero means no filtering
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgb_mask_t;

  // per pixel message from the scanner to the bins
  typedef struct packed {
    logic     valid;
    logic     first;
    logic     last;
    logic     hit;
    bin_idx_t bin;
  } hist_beat_t;

  typedef bin_cnt_t [hist_bins-1:0] bin_cnt_vec_t;

endpackage

`default_nettype wire
